// File: files.f
common/core_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
verilog/stream_fifo.sv
verilog/udp_echo_filter.sv
verilog/core_top.sv
tb/tb_clock.sv
tb/core_props.sv
tb/core_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := core_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG) || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/core_tb.sv
// ==============================
// Core testbench
// Drives the UART and UDP echo paths of
// core_top and scores what comes back
// ==============================

`timescale 1ns/1ps
`default_nettype none

module core_tb;

    localparam int clks_per_bit = 16;
    localparam int hs_limit     = 1000;

    logic        clk;
    logic        rst;
    logic        i_uart_rxd;
    logic        o_uart_txd;
    logic        i_rx_hdr_valid;
    logic        o_rx_hdr_ready;
    logic [31:0] i_rx_src_ip;
    logic [15:0] i_rx_src_port;
    logic [15:0] i_rx_dest_port;
    logic [15:0] i_rx_length;
    logic [7:0]  i_rx_payload_data;
    logic        i_rx_payload_valid;
    logic        o_rx_payload_ready;
    logic        i_rx_payload_last;
    logic        i_rx_payload_user;
    logic        o_tx_hdr_valid;
    logic        i_tx_hdr_ready;
    logic [31:0] o_tx_dest_ip;
    logic [15:0] o_tx_src_port;
    logic [15:0] o_tx_dest_port;
    logic [15:0] o_tx_length;
    logic [7:0]  o_tx_payload_data;
    logic        o_tx_payload_valid;
    logic        i_tx_payload_ready;
    logic        o_tx_payload_last;
    logic        o_tx_payload_user;

    // Expected results, oldest first
    logic [7:0]  exp_uart  [$];
    logic [79:0] exp_hdrs  [$];
    logic [9:0]  exp_beats [$];

    int   errors = 0;
    int   checks = 0;
    int   tests  = 0;
    logic bp_en  = 1'b0;

    tb_clock #(
        .period_ns    (100),
        .reset_cycles (4)
    ) tb_clock_i (
        .clk (clk),
        .rst (rst)
    );

    core_top #(
        .clks_per_bit    (clks_per_bit),
        .uart_fifo_depth (16),
        .udp_fifo_depth  (32)
    ) core_top_i (
        .clk                (clk),
        .rst                (rst),
        .i_uart_rxd         (i_uart_rxd),
        .o_uart_txd         (o_uart_txd),
        .i_rx_hdr_valid     (i_rx_hdr_valid),
        .o_rx_hdr_ready     (o_rx_hdr_ready),
        .i_rx_src_ip        (i_rx_src_ip),
        .i_rx_src_port      (i_rx_src_port),
        .i_rx_dest_port     (i_rx_dest_port),
        .i_rx_length        (i_rx_length),
        .i_rx_payload_data  (i_rx_payload_data),
        .i_rx_payload_valid (i_rx_payload_valid),
        .o_rx_payload_ready (o_rx_payload_ready),
        .i_rx_payload_last  (i_rx_payload_last),
        .i_rx_payload_user  (i_rx_payload_user),
        .o_tx_hdr_valid     (o_tx_hdr_valid),
        .i_tx_hdr_ready     (i_tx_hdr_ready),
        .o_tx_dest_ip       (o_tx_dest_ip),
        .o_tx_src_port      (o_tx_src_port),
        .o_tx_dest_port     (o_tx_dest_port),
        .o_tx_length        (o_tx_length),
        .o_tx_payload_data  (o_tx_payload_data),
        .o_tx_payload_valid (o_tx_payload_valid),
        .i_tx_payload_ready (i_tx_payload_ready),
        .o_tx_payload_last  (o_tx_payload_last),
        .o_tx_payload_user  (o_tx_payload_user)
    );

    bind core_top core_props core_props_i (
        .clk         (clk),
        .rst         (rst),
        .i_hdr_valid (o_tx_hdr_valid),
        .i_hdr_ready (i_tx_hdr_ready),
        .i_dest_ip   (o_tx_dest_ip),
        .i_src_port  (o_tx_src_port),
        .i_dest_port (o_tx_dest_port),
        .i_length    (o_tx_length),
        .i_pay_valid (o_tx_payload_valid),
        .i_pay_ready (i_tx_payload_ready),
        .i_pay_data  (o_tx_payload_data),
        .i_pay_last  (o_tx_payload_last),
        .i_pay_user  (o_tx_payload_user),
        .i_txd       (o_uart_txd),
        .i_tx_busy   (uart_tx_busy)
    );

    task automatic note_failure(input string what);
        errors++;
        $display("Failure at %0t ns: %s", $time, what);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("** Error: %s = 0x%0h, expected 0x%0h at %0t ns", name, got, exp, $time);
        end
    endtask

    task automatic end_test(input string name, input int err_start);
        tests++;
        $display("test %-14s %s, %0d errors", name,
                 (errors == err_start) ? "ok" : "failed", errors - err_start);
    endtask

    // One 8N1 frame followed by one idle bit
    task automatic send_uart_byte(input logic [7:0] data);
        logic [9:0] frame;
        int         i;
        frame = {1'b1, data, 1'b0};
        for (i = 0; i < 10; i++) begin
            @(posedge clk);
            #1;
            i_uart_rxd = frame[i];
            repeat (clks_per_bit - 1) @(posedge clk);
        end
        repeat (clks_per_bit) @(posedge clk);
    endtask

    task automatic send_frame(input logic [15:0] dport, input int len);
        logic [31:0] sip;
        logic [15:0] sport;
        logic [15:0] ulen;
        logic [7:0]  data;
        logic        last;
        logic        user;
        int          t;
        int          k;
        sip   = $urandom;
        sport = 16'($urandom);
        ulen  = 16'(len + 8);
        // Reply goes back to the sender with the ports swapped
        if (dport == core_pkg::echo_port) begin
            exp_hdrs.push_back({sip, dport, sport, ulen});
        end
        @(posedge clk);
        #1;
        i_rx_hdr_valid = 1'b1;
        i_rx_src_ip    = sip;
        i_rx_src_port  = sport;
        i_rx_dest_port = dport;
        i_rx_length    = ulen;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (!o_rx_hdr_ready && t < hs_limit);
        assert (o_rx_hdr_ready) else note_failure("timeout waiting for o_rx_hdr_ready");
        @(posedge clk);
        #1;
        i_rx_hdr_valid = 1'b0;
        for (k = 0; k < len; k++) begin
            data = 8'($urandom);
            last = (k == len - 1);
            user = 1'($urandom);
            if (dport == core_pkg::echo_port) begin
                exp_beats.push_back({data, last, user});
            end
            i_rx_payload_valid = 1'b1;
            i_rx_payload_data  = data;
            i_rx_payload_last  = last;
            i_rx_payload_user  = user;
            t = 0;
            do begin
                @(negedge clk);
                t++;
            end while (!o_rx_payload_ready && t < hs_limit);
            assert (o_rx_payload_ready) else begin
                note_failure("timeout waiting for o_rx_payload_ready");
            end
            @(posedge clk);
            #1;
        end
        i_rx_payload_valid = 1'b0;
        i_rx_payload_last  = 1'b0;
    endtask

    task automatic wait_drained(input int limit);
        int t;
        t = 0;
        while (exp_uart.size() + exp_hdrs.size() + exp_beats.size() != 0 && t < limit) begin
            @(negedge clk);
            t++;
        end
        assert (exp_uart.size() + exp_hdrs.size() + exp_beats.size() == 0) else begin
            note_failure("timeout waiting for the echoed data");
        end
    endtask

    // Random stalls on the transmit side, payload stalls often enough to fill the FIFO
    initial begin : ready_driver
        i_tx_hdr_ready     = 1'b1;
        i_tx_payload_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            i_tx_hdr_ready     = !bp_en || ($urandom_range(3, 0) != 0);
            i_tx_payload_ready = !bp_en || ($urandom_range(1, 0) != 0);
        end
    end

    // Decodes o_uart_txd at bit centres
    initial begin : uart_monitor
        logic [7:0] got;
        int         i;
        forever begin
            @(negedge clk);
            if (!rst && o_uart_txd == 1'b0) begin
                repeat (clks_per_bit / 2) @(negedge clk);
                for (i = 0; i < 8; i++) begin
                    repeat (clks_per_bit) @(negedge clk);
                    got[i] = o_uart_txd;
                end
                repeat (clks_per_bit) @(negedge clk);
                assert (o_uart_txd === 1'b1) else note_failure("low stop bit on o_uart_txd");
                assert (exp_uart.size() != 0) else note_failure("unexpected byte on o_uart_txd");
                if (exp_uart.size() != 0) begin
                    check_value("o_uart_txd", 32'(got), 32'(exp_uart.pop_front()));
                end
            end
        end
    end

    // Transfers happen at the next rising edge
    initial begin : udp_monitor
        logic [79:0] hdr;
        logic [9:0]  beat;
        forever begin
            @(negedge clk);
            if (!rst && o_tx_hdr_valid && i_tx_hdr_ready) begin
                assert (exp_hdrs.size() != 0) else note_failure("unexpected transmit header");
                if (exp_hdrs.size() != 0) begin
                    hdr = exp_hdrs.pop_front();
                    check_value("o_tx_dest_ip", o_tx_dest_ip, hdr[79:48]);
                    check_value("o_tx_src_port", 32'(o_tx_src_port), 32'(hdr[47:32]));
                    check_value("o_tx_dest_port", 32'(o_tx_dest_port), 32'(hdr[31:16]));
                    check_value("o_tx_length", 32'(o_tx_length), 32'(hdr[15:0]));
                end
            end
            if (!rst && o_tx_payload_valid && i_tx_payload_ready) begin
                assert (exp_beats.size() != 0) else note_failure("unexpected transmit beat");
                if (exp_beats.size() != 0) begin
                    beat = exp_beats.pop_front();
                    check_value("o_tx_payload_data", 32'(o_tx_payload_data), 32'(beat[9:2]));
                    check_value("o_tx_payload_last", 32'(o_tx_payload_last), 32'(beat[1]));
                    check_value("o_tx_payload_user", 32'(o_tx_payload_user), 32'(beat[0]));
                end
            end
        end
    end

    initial begin : main
        int          err_start;
        int          t;
        int          n;
        logic [7:0]  b;
        logic [15:0] port;

        void'($urandom(94517));
        i_uart_rxd         = 1'b1;
        i_rx_hdr_valid     = 1'b0;
        i_rx_src_ip        = '0;
        i_rx_src_port      = '0;
        i_rx_dest_port     = '0;
        i_rx_length        = '0;
        i_rx_payload_data  = '0;
        i_rx_payload_valid = 1'b0;
        i_rx_payload_last  = 1'b0;
        i_rx_payload_user  = 1'b0;

        err_start = errors;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (rst && t < 20);
        assert (!rst) else note_failure("reset never released");
        check_value("o_tx_hdr_valid", 32'(o_tx_hdr_valid), 32'h0);
        check_value("o_tx_payload_valid", 32'(o_tx_payload_valid), 32'h0);
        check_value("o_uart_txd", 32'(o_uart_txd), 32'h1);
        check_value("o_rx_hdr_ready", 32'(o_rx_hdr_ready), 32'h1);
        end_test("reset state", err_start);

        err_start = errors;
        for (n = 0; n < 8; n++) begin
            b = 8'($urandom);
            exp_uart.push_back(b);
            send_uart_byte(b);
        end
        wait_drained(40 * clks_per_bit);
        end_test("uart echo", err_start);

        err_start = errors;
        send_frame(core_pkg::echo_port, 1 + int'($urandom_range(11, 0)));
        wait_drained(hs_limit);
        end_test("echo port", err_start);

        // Nothing may come out, so watch for a while
        err_start = errors;
        do begin
            port = 16'($urandom);
        end while (port == core_pkg::echo_port);
        send_frame(port, 10);
        repeat (20) @(negedge clk);
        check_value("o_rx_hdr_ready", 32'(o_rx_hdr_ready), 32'h1);
        end_test("other port", err_start);

        // Frames longer than the payload FIFO
        err_start = errors;
        bp_en = 1'b1;
        for (n = 0; n < 3; n++) begin
            send_frame(core_pkg::echo_port, 40 + int'($urandom_range(20, 0)));
        end
        wait_drained(4 * hs_limit);
        bp_en = 1'b0;
        end_test("back-pressure", err_start);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/core_props.sv
// ==============================
// Core properties
// Handshake stability, UART idle level and
// echo-port filtering on core_top outputs
// ==============================

`timescale 1ns/1ps
`default_nettype none

module core_props (
    input wire        clk,
    input wire        rst,
    input wire        i_hdr_valid,
    input wire        i_hdr_ready,
    input wire [31:0] i_dest_ip,
    input wire [15:0] i_src_port,
    input wire [15:0] i_dest_port,
    input wire [15:0] i_length,
    input wire        i_pay_valid,
    input wire        i_pay_ready,
    input wire [7:0]  i_pay_data,
    input wire        i_pay_last,
    input wire        i_pay_user,
    input wire        i_txd,
    input wire        i_tx_busy
);

    logic [79:0] hdr_fields;
    logic [9:0]  beat;

    assign hdr_fields = {i_dest_ip, i_src_port, i_dest_port, i_length};
    assign beat       = {i_pay_data, i_pay_last, i_pay_user};

    // A stalled header keeps valid and all fields
    hdr_held: assert property (@(posedge clk) disable iff (rst)
        i_hdr_valid && !i_hdr_ready |=> i_hdr_valid && $stable(hdr_fields))
        else $error("transmit header dropped or changed while stalled");

    // Same for a stalled payload beat
    beat_held: assert property (@(posedge clk) disable iff (rst)
        i_pay_valid && !i_pay_ready |=> i_pay_valid && $stable(beat))
        else $error("transmit payload beat dropped or changed while stalled");

    txd_idle_high: assert property (@(posedge clk) disable iff (rst)
        !i_tx_busy |-> i_txd)
        else $error("serial line low while transmitter idle");

    // Reply source port is the original destination port
    echo_only: assert property (@(posedge clk) disable iff (rst)
        i_hdr_valid |-> i_src_port == core_pkg::echo_port)
        else $error("transmit header for a port other than the echo port");

endmodule

`default_nettype wire

// File: tb/tb_clock.sv
// ==============================
// Testbench clock
// Free-running clock and a synchronous
// reset held for a few cycles
// ==============================

`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int period_ns    = 100,
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // Released just after a rising edge
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: verilog/core_top.sv
// ==============================
// Core top level
// UART byte echo and UDP echo on port 1234,
// each buffered through its own FIFO
// ==============================

`timescale 1ns/1ps
`default_nettype none

module core_top #(
    parameter int clks_per_bit    = core_pkg::uart_default_clks_per_bit,
    parameter int uart_fifo_depth = core_pkg::uart_fifo_default_depth,
    parameter int udp_fifo_depth  = core_pkg::udp_fifo_default_depth
) (
    input  wire                   clk,
    input  wire                   rst,

    // UART, 8N1
    input  wire                   i_uart_rxd,
    output logic                  o_uart_txd,

    // UDP receive header
    input  wire                   i_rx_hdr_valid,
    output logic                  o_rx_hdr_ready,
    input  core_pkg::ipv4_addr_t  i_rx_src_ip,
    input  core_pkg::udp_port_t   i_rx_src_port,
    input  core_pkg::udp_port_t   i_rx_dest_port,
    input  core_pkg::udp_length_t i_rx_length,

    // UDP receive payload
    input  wire [7:0]             i_rx_payload_data,
    input  wire                   i_rx_payload_valid,
    output logic                  o_rx_payload_ready,
    input  wire                   i_rx_payload_last,
    input  wire                   i_rx_payload_user,

    // UDP transmit header
    output logic                  o_tx_hdr_valid,
    input  wire                   i_tx_hdr_ready,
    output core_pkg::ipv4_addr_t  o_tx_dest_ip,
    output core_pkg::udp_port_t   o_tx_src_port,
    output core_pkg::udp_port_t   o_tx_dest_port,
    output core_pkg::udp_length_t o_tx_length,

    // UDP transmit payload
    output logic [7:0]            o_tx_payload_data,
    output logic                  o_tx_payload_valid,
    input  wire                   i_tx_payload_ready,
    output logic                  o_tx_payload_last,
    output logic                  o_tx_payload_user
);

    core_pkg::uart_byte_t uart_rx_data;
    logic                 uart_rx_valid;
    core_pkg::uart_byte_t uart_tx_data;
    logic                 uart_tx_valid;
    logic                 uart_tx_busy;

    core_pkg::udp_beat_t  rx_beat;
    core_pkg::udp_beat_t  tx_beat;
    logic                 udp_fifo_valid;
    logic                 udp_fifo_ready;

    uart_rx #(
        .clks_per_bit (clks_per_bit)
    ) uart_rx_i (
        .clk     (clk),
        .rst     (rst),
        .i_rxd   (i_uart_rxd),
        .o_data  (uart_rx_data),
        .o_valid (uart_rx_valid)
    );

    // Bytes arriving while full are lost
    stream_fifo #(
        .payload_t (core_pkg::uart_byte_t),
        .depth     (uart_fifo_depth)
    ) uart_fifo (
        .clk     (clk),
        .rst     (rst),
        .i_data  (uart_rx_data),
        .i_valid (uart_rx_valid),
        .o_ready (),
        .o_data  (uart_tx_data),
        .o_valid (uart_tx_valid),
        .i_ready (!uart_tx_busy)
    );

    uart_tx #(
        .clks_per_bit (clks_per_bit)
    ) uart_tx_i (
        .clk     (clk),
        .rst     (rst),
        .i_data  (uart_tx_data),
        .i_valid (uart_tx_valid),
        .o_txd   (o_uart_txd),
        .o_busy  (uart_tx_busy)
    );

    udp_echo_filter udp_echo_filter_i (
        .clk                (clk),
        .rst                (rst),
        .i_rx_hdr_valid     (i_rx_hdr_valid),
        .o_rx_hdr_ready     (o_rx_hdr_ready),
        .i_rx_src_ip        (i_rx_src_ip),
        .i_rx_src_port      (i_rx_src_port),
        .i_rx_dest_port     (i_rx_dest_port),
        .i_rx_length        (i_rx_length),
        .o_tx_hdr_valid     (o_tx_hdr_valid),
        .i_tx_hdr_ready     (i_tx_hdr_ready),
        .o_tx_dest_ip       (o_tx_dest_ip),
        .o_tx_src_port      (o_tx_src_port),
        .o_tx_dest_port     (o_tx_dest_port),
        .o_tx_length        (o_tx_length),
        .i_rx_payload_valid (i_rx_payload_valid),
        .i_rx_payload_last  (i_rx_payload_last),
        .o_rx_payload_ready (o_rx_payload_ready),
        .o_fifo_valid       (udp_fifo_valid),
        .i_fifo_ready       (udp_fifo_ready)
    );

    assign rx_beat = '{data: i_rx_payload_data, last: i_rx_payload_last,
                       user: i_rx_payload_user};

    stream_fifo #(
        .payload_t (core_pkg::udp_beat_t),
        .depth     (udp_fifo_depth)
    ) udp_payload_fifo (
        .clk     (clk),
        .rst     (rst),
        .i_data  (rx_beat),
        .i_valid (udp_fifo_valid),
        .o_ready (udp_fifo_ready),
        .o_data  (tx_beat),
        .o_valid (o_tx_payload_valid),
        .i_ready (i_tx_payload_ready)
    );

    assign o_tx_payload_data = tx_beat.data;
    assign o_tx_payload_last = tx_beat.last;
    assign o_tx_payload_user = tx_beat.user;

endmodule

`default_nettype wire

// File: verilog/udp_echo_filter.sv
// ==============================
// UDP echo filter
// Forwards frames for the echo port with the
// header turned around, consumes all others
// ==============================

`timescale 1ns/1ps
`default_nettype none

module udp_echo_filter (
    input  wire                   clk,
    input  wire                   rst,

    // Receive header
    input  wire                   i_rx_hdr_valid,
    output logic                  o_rx_hdr_ready,
    input  core_pkg::ipv4_addr_t  i_rx_src_ip,
    input  core_pkg::udp_port_t   i_rx_src_port,
    input  core_pkg::udp_port_t   i_rx_dest_port,
    input  core_pkg::udp_length_t i_rx_length,

    // Transmit header
    output logic                  o_tx_hdr_valid,
    input  wire                   i_tx_hdr_ready,
    output core_pkg::ipv4_addr_t  o_tx_dest_ip,
    output core_pkg::udp_port_t   o_tx_src_port,
    output core_pkg::udp_port_t   o_tx_dest_port,
    output core_pkg::udp_length_t o_tx_length,

    // Payload steering
    input  wire                   i_rx_payload_valid,
    input  wire                   i_rx_payload_last,
    output logic                  o_rx_payload_ready,
    output logic                  o_fifo_valid,
    input  wire                   i_fifo_ready
);

    logic match;
    logic hdr_xfer;
    logic last_xfer;
    // Set between header transfer and last payload byte
    logic frame_active;
    logic frame_fwd;

    assign match = i_rx_dest_port == core_pkg::echo_port;

    // No new header until the current payload is done
    assign o_tx_hdr_valid = i_rx_hdr_valid && match && !frame_active;
    assign o_rx_hdr_ready = !frame_active && (!match || i_tx_hdr_ready);

    // Reply goes back to the sender
    assign o_tx_dest_ip   = i_rx_src_ip;
    assign o_tx_src_port  = i_rx_dest_port;
    assign o_tx_dest_port = i_rx_src_port;
    assign o_tx_length    = i_rx_length;

    assign o_fifo_valid       = frame_active && frame_fwd && i_rx_payload_valid;
    // Dropped payload is always consumed
    assign o_rx_payload_ready = frame_active && (frame_fwd ? i_fifo_ready : 1'b1);

    assign hdr_xfer  = i_rx_hdr_valid && o_rx_hdr_ready;
    assign last_xfer = i_rx_payload_valid && o_rx_payload_ready && i_rx_payload_last;

    // Decision is taken once per frame and held
    always_ff @(posedge clk) begin
        if (rst) begin
            frame_active <= 1'b0;
            frame_fwd    <= 1'b0;
        end else if (hdr_xfer) begin
            frame_active <= 1'b1;
            frame_fwd    <= match;
        end else if (last_xfer) begin
            frame_active <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/stream_fifo.sv
// ==============================
// Stream FIFO
// Circular buffer, first word falls through,
// payload type set by parameter
// ==============================

`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 16
) (
    input  wire      clk,
    input  wire      rst,
    input  payload_t i_data,
    input  wire      i_valid,
    output logic     o_ready,
    output payload_t o_data,
    output logic     o_valid,
    input  wire      i_ready
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);
    localparam logic [ptr_w-1:0] last_ptr = ptr_w'(depth - 1);

    payload_t         mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_wr;
    logic             do_rd;

    assign o_ready = count != cnt_w'(depth);
    assign o_valid = count != '0;
    assign do_wr   = i_valid && o_ready;
    assign do_rd   = o_valid && i_ready;

    // Head entry is always on the output
    assign o_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: uart/uart_tx.sv
// ==============================
// UART transmitter
// 8N1 serial output with a busy level
// ==============================

`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
    parameter int clks_per_bit = core_pkg::uart_default_clks_per_bit
) (
    input  wire                  clk,
    input  wire                  rst,
    input  core_pkg::uart_byte_t i_data,
    input  wire                  i_valid,
    output logic                 o_txd,
    output logic                 o_busy
);

    localparam int cnt_w = $clog2(clks_per_bit + 1);
    localparam logic [cnt_w-1:0] full_cnt = cnt_w'(clks_per_bit - 1);

    logic [cnt_w-1:0] clk_cnt;
    logic [3:0]       bit_cnt;
    // Data bits followed by the stop bit
    logic [8:0]       frame;
    logic             load;
    logic             bit_end;

    assign load    = i_valid && !o_busy;
    assign bit_end = o_busy && (clk_cnt == full_cnt);

    always_ff @(posedge clk) begin
        if (rst) begin
            o_busy  <= 1'b0;
            o_txd   <= 1'b1;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (load) begin
            // Start bit goes out right away
            o_busy  <= 1'b1;
            o_txd   <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (bit_end) begin
            clk_cnt <= '0;
            if (bit_cnt == 4'd9) begin
                o_busy <= 1'b0;
            end else begin
                o_txd   <= frame[0];
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else if (o_busy) begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            frame <= {1'b1, i_data};
        end else if (bit_end) begin
            frame <= {1'b1, frame[8:1]};
        end
    end

endmodule

`default_nettype wire

// File: uart/uart_rx.sv
// ==============================
// UART receiver
// 8N1 serial input, sampled at bit centres,
// one-cycle strobe per good byte
// ==============================

`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
    parameter int clks_per_bit = core_pkg::uart_default_clks_per_bit
) (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  i_rxd,
    output core_pkg::uart_byte_t o_data,
    output logic                 o_valid
);

    localparam int cnt_w = $clog2(clks_per_bit + 1);
    localparam logic [cnt_w-1:0] full_cnt = cnt_w'(clks_per_bit - 1);
    localparam logic [cnt_w-1:0] half_cnt = cnt_w'(clks_per_bit / 2 - 1);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } state_t;

    state_t               state;
    logic [1:0]           rxd_sync;
    logic                 rxd;
    logic [cnt_w-1:0]     clk_cnt;
    logic [2:0]           bit_idx;
    core_pkg::uart_byte_t shift_reg;

    // Two-stage synchronizer, line idles high
    always_ff @(posedge clk) begin
        if (rst) begin
            rxd_sync <= 2'b11;
        end else begin
            rxd_sync <= {rxd_sync[0], i_rxd};
        end
    end

    assign rxd = rxd_sync[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= st_idle;
            clk_cnt <= '0;
            bit_idx <= '0;
            o_valid <= 1'b0;
        end else begin
            o_valid <= 1'b0;
            case (state)
                st_idle: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (!rxd) begin
                        state <= st_start;
                    end
                end
                st_start: begin
                    // Glitch shorter than half a bit goes back to idle
                    if (clk_cnt == half_cnt) begin
                        clk_cnt <= '0;
                        state   <= rxd ? st_idle : st_data;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                st_data: begin
                    if (clk_cnt == full_cnt) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= st_stop;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: begin
                    // Low stop bit means a framing error, byte is dropped
                    if (clk_cnt == full_cnt) begin
                        clk_cnt <= '0;
                        state   <= st_idle;
                        o_valid <= rxd;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if (state == st_data && clk_cnt == full_cnt) begin
            shift_reg <= {rxd, shift_reg[7:1]};
        end
    end

    assign o_data = shift_reg;

endmodule

`default_nettype wire

// File: common/core_pkg.sv
// ==============================
// Core package
// Shared constants and payload types for the
// UART echo path and the UDP echo filter
// ==============================

`default_nettype none

package core_pkg;

    // UDP destination port that gets echoed back
    localparam logic [15:0] echo_port = 16'd1234;

    // 125 MHz clock, 115200 baud
    localparam int uart_default_clks_per_bit = 1085;

    // Default FIFO depths in entries
    localparam int uart_fifo_default_depth = 256;
    localparam int udp_fifo_default_depth  = 8192;

    // One serial data byte
    typedef logic [7:0] uart_byte_t;

    // One UDP payload beat, user marks a bad frame
    typedef struct packed {
        logic [7:0] data;
        logic       last;
        logic       user;
    } udp_beat_t;

    // UDP and IPv4 header fields
    typedef logic [15:0] udp_port_t;
    typedef logic [31:0] ipv4_addr_t;
    typedef logic [15:0] udp_length_t;

endpackage

`default_nettype wire
